// ==== hdl/acc_pkg.sv ====
`default_nettype none

package acc_pkg;

  // bus geometry
  localparam int APB_ADDR_WIDTH = 12;
  localparam int APB_DATA_WIDTH = 32;

  // word index, taken from paddr[11:2]
  typedef enum logic [9:0] {
    REG_ACC_IN  = 10'd1,
    REG_ACC_OUT = 10'd2,
    REG_CONFIG  = 10'd3,
    REG_STATUS  = 10'd5,
    REG_NTAPS   = 10'd6,
    REG_TAP_0   = 10'd7,
    REG_TAP_1   = 10'd8,
    REG_TAP_2   = 10'd9,
    REG_TAP_3   = 10'd10,
    REG_TAP_4   = 10'd11,
    REG_TAP_5   = 10'd12,
    REG_TAP_6   = 10'd13,
    REG_TAP_7   = 10'd14
  } reg_addr_e;

  // bits of REG_CONFIG
  localparam int CFG_FILTER_CLEAR = 0;
  localparam int CFG_FIFO_CLEAR   = 1;
  localparam int CFG_FIFO_EN      = 2;

  // bits of REG_STATUS
  localparam int STAT_EMPTY    = 0;
  localparam int STAT_FULL     = 1;
  localparam int STAT_OVERFLOW = 2;

  localparam logic [APB_DATA_WIDTH-1:0] READ_UNMAPPED = '1;

endpackage

`default_nettype wire

// ==== hdl/acc_ifs.sv ====
`timescale 1ns/100ps
`default_nettype none

// filter configuration and sample input, owned by the register block
interface fir_cfg_if #(
  parameter int NTAPS = 8,
  parameter int IW    = 12
);
  localparam int NW = $clog2(NTAPS + 1);

  logic signed [IW-1:0] taps [NTAPS];
  logic [NW-1:0]        ntaps;
  logic signed [IW-1:0] sample;
  logic                 sample_stb;
  logic                 filter_clear;

  modport regs   (output taps, ntaps, sample, sample_stb, filter_clear);
  modport filter (input  taps, ntaps, sample, sample_stb, filter_clear);
endinterface

// result path from the filter through the FIFO to the register block
interface result_if #(
  parameter int WIDTH = 31
);
  logic             push;
  logic [WIDTH-1:0] data;
  logic             pop;
  logic             clear;
  logic             en;
  logic [WIDTH-1:0] head;
  logic             empty;
  logic             full;
  logic             overflow;

  modport producer (output push, data);
  modport consumer (output pop, clear, en, input head, empty, full, overflow);
  modport fifo     (input push, data, pop, clear, en, output head, empty, full, overflow);
endinterface

`default_nettype wire

// ==== hdl/apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_regs #(
  parameter int NTAPS = 8,
  parameter int IW    = 12
) (
  input  wire logic                                i_clk,
  input  wire logic                                i_reset,
  input  wire logic [acc_pkg::APB_ADDR_WIDTH-1:0]  i_paddr,
  input  wire logic [acc_pkg::APB_DATA_WIDTH-1:0]  i_pwdata,
  input  wire logic                                i_pwrite,
  input  wire logic                                i_psel,
  input  wire logic                                i_penable,
  output logic      [acc_pkg::APB_DATA_WIDTH-1:0]  o_prdata,
  fir_cfg_if.regs                                  cfg,
  result_if.consumer                               res
);

  localparam int AW = acc_pkg::APB_ADDR_WIDTH;
  localparam int DW = acc_pkg::APB_DATA_WIDTH;
  localparam int NW = $clog2(NTAPS + 1);

  logic [2:0]           cfg_q;
  logic [NW-1:0]        ntaps_q;
  logic signed [IW-1:0] tap_q [NTAPS];
  logic [AW-3:0]        word_raw;
  acc_pkg::reg_addr_e   word_idx;
  logic                 wr_acc;
  logic                 rd_acc;
  logic                 ntaps_ok;

  // word addressed, byte offset ignored
  assign word_raw = i_paddr[AW-1:2];
  assign word_idx = acc_pkg::reg_addr_e'(word_raw);

  assign wr_acc = i_psel & i_penable & i_pwrite;
  assign rd_acc = i_psel & i_penable & ~i_pwrite;

  // only 1..NTAPS is a legal tap count
  assign ntaps_ok = (i_pwdata >= DW'(1)) && (i_pwdata <= DW'(NTAPS));

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      cfg_q   <= '0;
      ntaps_q <= NW'(NTAPS);
      for (int k = 0; k < NTAPS; k++)
        tap_q[k] <= '0;
    end
    else if (wr_acc)
    begin
      case (word_idx)
        acc_pkg::REG_CONFIG:
        begin
          cfg_q[acc_pkg::CFG_FILTER_CLEAR] <= i_pwdata[acc_pkg::CFG_FILTER_CLEAR];
          cfg_q[acc_pkg::CFG_FIFO_CLEAR]   <= i_pwdata[acc_pkg::CFG_FIFO_CLEAR];
          cfg_q[acc_pkg::CFG_FIFO_EN]      <= i_pwdata[acc_pkg::CFG_FIFO_EN];
        end
        acc_pkg::REG_NTAPS:
        begin
          if (ntaps_ok)
            ntaps_q <= i_pwdata[NW-1:0];
        end
        default:
        begin
          // tap registers sit in a contiguous block
          for (int k = 0; k < NTAPS; k++)
            if (word_raw == 10'(acc_pkg::REG_TAP_0) + 10'(k))
              tap_q[k] <= i_pwdata[IW-1:0];
        end
      endcase
    end
  end

  // filter side
  assign cfg.taps         = tap_q;
  assign cfg.ntaps        = ntaps_q;
  assign cfg.sample       = i_pwdata[IW-1:0];
  assign cfg.sample_stb   = wr_acc && (word_idx == acc_pkg::REG_ACC_IN);
  assign cfg.filter_clear = cfg_q[acc_pkg::CFG_FILTER_CLEAR];

  // fifo side, the pop lands on the same edge that ends the read
  assign res.pop   = rd_acc && (word_idx == acc_pkg::REG_ACC_OUT);
  assign res.clear = cfg_q[acc_pkg::CFG_FIFO_CLEAR];
  assign res.en    = cfg_q[acc_pkg::CFG_FIFO_EN];

  always_comb
  begin
    o_prdata = acc_pkg::READ_UNMAPPED;
    case (word_idx)
      acc_pkg::REG_ACC_OUT:
        o_prdata = DW'($signed(res.head));
      acc_pkg::REG_CONFIG:
        o_prdata = DW'(cfg_q);
      acc_pkg::REG_STATUS:
      begin
        o_prdata = '0;
        o_prdata[acc_pkg::STAT_EMPTY]    = res.empty;
        o_prdata[acc_pkg::STAT_FULL]     = res.full;
        o_prdata[acc_pkg::STAT_OVERFLOW] = res.overflow;
      end
      acc_pkg::REG_NTAPS:
        o_prdata = DW'(ntaps_q);
      default:
      begin
        for (int k = 0; k < NTAPS; k++)
          if (word_raw == 10'(acc_pkg::REG_TAP_0) + 10'(k))
            o_prdata = DW'(tap_q[k]);
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/fir_filter.sv ====
`timescale 1ns/100ps
`default_nettype none

module fir_filter #(
  parameter int NTAPS = 8,
  parameter int IW    = 12
) (
  input  wire logic   i_clk,
  input  wire logic   i_reset,
  fir_cfg_if.filter   cfg,
  result_if.producer  res
);

  localparam int PW = 2 * IW;
  localparam int OW = 2 * IW + 7;

  logic signed [IW-1:0] dly   [NTAPS];
  logic signed [IW-1:0] x_in  [NTAPS];
  logic signed [PW-1:0] prod  [NTAPS];
  logic signed [OW-1:0] sum_d;
  logic signed [OW-1:0] sum_q;
  logic [1:0]           vld;

  // line contents as they look once the new sample is shifted in
  always_comb
  begin
    x_in[0] = cfg.sample;
    for (int k = 1; k < NTAPS; k++)
      x_in[k] = dly[k-1];
  end

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      vld <= '0;
      for (int k = 0; k < NTAPS; k++)
        dly[k] <= '0;
    end
    else if (cfg.filter_clear)
    begin
      vld <= '0;
      for (int k = 0; k < NTAPS; k++)
        dly[k] <= '0;
    end
    else
    begin
      vld <= {vld[0], cfg.sample_stb};
      if (cfg.sample_stb)
        dly <= x_in;
    end
  end

  // stage 1, products formed on the shift edge, unused taps give zero
  always_ff @(posedge i_clk)
  begin
    if (cfg.sample_stb)
    begin
      for (int k = 0; k < NTAPS; k++)
      begin
        if (k < cfg.ntaps)
          prod[k] <= cfg.taps[k] * x_in[k];
        else
          prod[k] <= '0;
      end
    end
  end

  always_comb
  begin
    sum_d = '0;
    for (int k = 0; k < NTAPS; k++)
      sum_d = sum_d + OW'(prod[k]);
  end

  // stage 2
  always_ff @(posedge i_clk)
  begin
    if (vld[0])
      sum_q <= sum_d;
  end

  assign res.push = vld[1];
  assign res.data = sum_q;

endmodule

`default_nettype wire

// ==== hdl/result_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module result_fifo #(
  parameter int DEPTH = 16,
  parameter int WIDTH = 31
) (
  input  wire logic i_clk,
  input  wire logic i_reset,
  result_if.fifo    res
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [AW:0]      count;
  logic             overflow_q;
  logic             do_push;
  logic             do_pop;

  assign res.empty    = (count == '0);
  assign res.full     = (count == (AW+1)'(DEPTH));
  assign res.overflow = overflow_q;
  assign res.head     = res.empty ? '0 : mem[rd_ptr];

  // disabled fifo drops silently, only a full one flags it
  assign do_push = res.push & res.en & ~res.full & ~res.clear;
  assign do_pop  = res.pop & ~res.empty & ~res.clear;

  always_ff @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_q <= 1'b0;
    end
    else if (res.clear)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow_q <= 1'b0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + (AW+1)'(do_push) - (AW+1)'(do_pop);
      if (res.push && res.en && res.full)
        overflow_q <= 1'b1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= res.data;
  end

endmodule

`default_nettype wire

// ==== hdl/apb_acc_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_acc_top #(
  parameter int NTAPS      = 8,
  parameter int IW         = 12,
  parameter int FIFO_DEPTH = 16
) (
  input  wire logic                                i_clk,
  input  wire logic                                i_reset,
  input  wire logic [acc_pkg::APB_ADDR_WIDTH-1:0]  i_paddr,
  input  wire logic [acc_pkg::APB_DATA_WIDTH-1:0]  i_pwdata,
  input  wire logic                                i_pwrite,
  input  wire logic                                i_psel,
  input  wire logic                                i_penable,
  output logic      [acc_pkg::APB_DATA_WIDTH-1:0]  o_prdata,
  output logic                                     o_pready,
  output logic                                     o_pslverr
);

  // full precision result width
  localparam int OW = 2 * IW + 7;

  fir_cfg_if #(.NTAPS(NTAPS), .IW(IW)) cfg_bus ();
  result_if  #(.WIDTH(OW))             res_bus ();

  // no wait states, no error responses
  assign o_pready  = 1'b1;
  assign o_pslverr = 1'b0;

  apb_regs #(
    .NTAPS (NTAPS),
    .IW    (IW)
  ) u_regs (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .i_pwrite  (i_pwrite),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .o_prdata  (o_prdata),
    .cfg       (cfg_bus.regs),
    .res       (res_bus.consumer)
  );

  fir_filter #(
    .NTAPS (NTAPS),
    .IW    (IW)
  ) u_filter (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .cfg     (cfg_bus.filter),
    .res     (res_bus.producer)
  );

  result_fifo #(
    .DEPTH (FIFO_DEPTH),
    .WIDTH (OW)
  ) u_fifo (
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .res     (res_bus.fifo)
  );

endmodule

`default_nettype wire

// ==== dv/acc_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module acc_checker #(
  parameter int NTAPS      = 8,
  parameter int IW         = 12,
  parameter int FIFO_DEPTH = 16
) (
  input  wire logic        i_clk,
  input  wire logic        i_reset,
  input  wire logic [11:0] i_paddr,
  input  wire logic [31:0] i_pwdata,
  input  wire logic        i_pwrite,
  input  wire logic        i_psel,
  input  wire logic        i_penable,
  input  wire logic [31:0] i_prdata,
  input  wire logic        i_pready,
  input  wire logic        i_pslverr
);

  int          errors = 0;
  int          tap_m [NTAPS];
  int          hist  [NTAPS];
  int          ntaps_m;
  logic [2:0]  cfg_m;
  logic        v0;
  logic        v1;
  int          r0;
  int          r1;
  int          fifo_q [$];
  logic        ovf_m;
  logic        was_full;
  logic [31:0] exp_val;
  logic [9:0]  idx;
  logic        wr_acc;
  logic        rd_acc;

  assign idx    = i_paddr[11:2];
  assign wr_acc = i_psel & i_penable & i_pwrite;
  assign rd_acc = i_psel & i_penable & ~i_pwrite;

  // sum of tap k times the sample written k writes earlier
  function automatic int ref_fir();
    int acc;
    acc = 0;
    for (int k = 0; k < ntaps_m; k++)
      acc += tap_m[k] * hist[k];
    return acc;
  endfunction

  task automatic compare_reg(input string name, input logic [31:0] expected);
    if (i_prdata !== expected)
    begin
      $display("mismatch %s expected %08h actual %08h", name, expected, i_prdata);
      errors++;
    end
  endtask

  // model steps use the values from before the edge
  always @(posedge i_clk or posedge i_reset)
  begin
    if (i_reset)
    begin
      cfg_m   = '0;
      ntaps_m = NTAPS;
      v0      = 1'b0;
      v1      = 1'b0;
      r0      = 0;
      r1      = 0;
      ovf_m   = 1'b0;
      fifo_q.delete();
      for (int k = 0; k < NTAPS; k++)
      begin
        tap_m[k] = 0;
        hist[k]  = 0;
      end
    end
    else
    begin
      // result fifo
      if (cfg_m[acc_pkg::CFG_FIFO_CLEAR])
      begin
        fifo_q.delete();
        ovf_m = 1'b0;
      end
      else
      begin
        was_full = (fifo_q.size() == FIFO_DEPTH);
        if (v1 && cfg_m[acc_pkg::CFG_FIFO_EN] && was_full)
          ovf_m = 1'b1;
        if (rd_acc && idx == acc_pkg::REG_ACC_OUT && fifo_q.size() > 0)
          void'(fifo_q.pop_front());
        if (v1 && cfg_m[acc_pkg::CFG_FIFO_EN] && !was_full)
          fifo_q.push_back(r1);
      end
      // two stage filter
      if (cfg_m[acc_pkg::CFG_FILTER_CLEAR])
      begin
        v0 = 1'b0;
        v1 = 1'b0;
        for (int k = 0; k < NTAPS; k++)
          hist[k] = 0;
      end
      else
      begin
        v1 = v0;
        r1 = r0;
        v0 = wr_acc && (idx == acc_pkg::REG_ACC_IN);
        if (v0)
        begin
          for (int k = NTAPS - 1; k > 0; k--)
            hist[k] = hist[k-1];
          hist[0] = $signed(i_pwdata[IW-1:0]);
          r0 = ref_fir();
        end
      end
      // register writes
      if (wr_acc)
      begin
        if (idx == acc_pkg::REG_CONFIG)
          cfg_m = i_pwdata[2:0];
        else if (idx == acc_pkg::REG_NTAPS && i_pwdata >= 1 && i_pwdata <= NTAPS)
          ntaps_m = int'(i_pwdata);
        else if (idx >= acc_pkg::REG_TAP_0 && idx < acc_pkg::REG_TAP_0 + NTAPS)
          tap_m[idx - 10'(acc_pkg::REG_TAP_0)] = $signed(i_pwdata[IW-1:0]);
      end
    end
  end

  // read data is stable in the middle of the access cycle
  always @(negedge i_clk)
  begin
    if (!i_reset && i_psel && i_penable)
    begin
      if (i_pready !== 1'b1)
      begin
        $display("mismatch o_pready expected 1 actual %h", i_pready);
        errors++;
      end
      if (i_pslverr !== 1'b0)
      begin
        $display("mismatch o_pslverr expected 0 actual %h", i_pslverr);
        errors++;
      end
      if (!i_pwrite && idx == acc_pkg::REG_ACC_OUT)
      begin
        exp_val = (fifo_q.size() > 0) ? fifo_q[0] : 0;
        compare_reg("REG_ACC_OUT", exp_val);
      end
      else if (!i_pwrite && idx == acc_pkg::REG_STATUS)
      begin
        exp_val = '0;
        exp_val[acc_pkg::STAT_EMPTY]    = (fifo_q.size() == 0);
        exp_val[acc_pkg::STAT_FULL]     = (fifo_q.size() == FIFO_DEPTH);
        exp_val[acc_pkg::STAT_OVERFLOW] = ovf_m;
        compare_reg("REG_STATUS", exp_val);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_apb_acc.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_apb_acc;

  localparam int NTAPS      = 8;
  localparam int IW         = 12;
  localparam int FIFO_DEPTH = 16;
  localparam int WAIT_LIMIT = 40;

  logic        i_clk;
  logic        i_reset;
  logic [11:0] i_paddr;
  logic [31:0] i_pwdata;
  logic        i_pwrite;
  logic        i_psel;
  logic        i_penable;
  logic [31:0] o_prdata;
  logic        o_pready;
  logic        o_pslverr;

  integer      seed;
  int          tb_errors;
  int          tests_passed;
  int          tests_failed;
  int          err_mark;
  string       test_name;
  logic [31:0] rdata;
  logic [31:0] rnd;
  int          tap_val [NTAPS];

  apb_acc_top #(
    .NTAPS      (NTAPS),
    .IW         (IW),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .i_pwrite  (i_pwrite),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr)
  );

  acc_checker #(
    .NTAPS      (NTAPS),
    .IW         (IW),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_check (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .i_pwrite  (i_pwrite),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_prdata  (o_prdata),
    .i_pready  (o_pready),
    .i_pslverr (o_pslverr)
  );

  always #20 i_clk = ~i_clk;

  function automatic int total_errors();
    return tb_errors + u_check.errors;
  endfunction

  // setup cycle, access cycle, then idle
  task automatic apb_write(input logic [9:0] idx, input logic [31:0] data);
    @(posedge i_clk);
    i_paddr  <= {idx, 2'b00};
    i_pwdata <= data;
    i_pwrite <= 1'b1;
    i_psel   <= 1'b1;
    @(posedge i_clk);
    i_penable <= 1'b1;
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [9:0] idx, output logic [31:0] data);
    @(posedge i_clk);
    i_paddr  <= {idx, 2'b00};
    i_pwrite <= 1'b0;
    i_psel   <= 1'b1;
    @(posedge i_clk);
    i_penable <= 1'b1;
    @(negedge i_clk);
    data = o_prdata;
    @(posedge i_clk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp)
    begin
      $display("mismatch %s expected %08h actual %08h", name, exp, act);
      tb_errors++;
    end
  endtask

  task automatic check_reg(input logic [9:0] idx, input string name, input logic [31:0] exp);
    logic [31:0] data;
    apb_read(idx, data);
    check_value(name, data, exp);
  endtask

  task automatic wait_not_empty();
    logic [31:0] st;
    int          tries;
    tries = 0;
    apb_read(acc_pkg::REG_STATUS, st);
    while (st[acc_pkg::STAT_EMPTY] && tries < WAIT_LIMIT)
    begin
      tries++;
      apb_read(acc_pkg::REG_STATUS, st);
    end
    if (st[acc_pkg::STAT_EMPTY])
    begin
      $display("timeout waiting for a result to reach the FIFO");
      tb_errors++;
    end
  endtask

  // read results until the FIFO reports empty
  task automatic drain_fifo();
    logic [31:0] st;
    logic [31:0] data;
    int          tries;
    tries = 0;
    apb_read(acc_pkg::REG_STATUS, st);
    while (!st[acc_pkg::STAT_EMPTY] && tries < WAIT_LIMIT)
    begin
      tries++;
      apb_read(acc_pkg::REG_ACC_OUT, data);
      apb_read(acc_pkg::REG_STATUS, st);
    end
    if (!st[acc_pkg::STAT_EMPTY])
    begin
      $display("timeout draining the FIFO, it never became empty");
      tb_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_mark  = total_errors();
  endtask

  task automatic finish_test();
    if (total_errors() == err_mark)
    begin
      tests_passed++;
      $display("test %s: pass", test_name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: fail", test_name);
    end
  endtask

  initial
  begin
    i_clk        = 1'b0;
    i_reset      = 1'b1;
    i_paddr      = '0;
    i_pwdata     = '0;
    i_pwrite     = 1'b0;
    i_psel       = 1'b0;
    i_penable    = 1'b0;
    seed         = 32'h2ec0c805;
    tb_errors    = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;

    start_test("reset values");
    check_reg(acc_pkg::REG_CONFIG, "REG_CONFIG", 32'h0);
    check_reg(acc_pkg::REG_NTAPS, "REG_NTAPS", 32'd8);
    check_reg(acc_pkg::REG_STATUS, "REG_STATUS", 32'h1);
    check_reg(10'd0, "unmapped 0", acc_pkg::READ_UNMAPPED);
    check_reg(10'd15, "unmapped 15", acc_pkg::READ_UNMAPPED);
    finish_test();

    start_test("register readback");
    apb_write(acc_pkg::REG_TAP_0, 32'h0000_0800);
    apb_write(acc_pkg::REG_TAP_3, 32'h0000_07ff);
    apb_write(acc_pkg::REG_TAP_7, 32'habcd_e9c3);
    check_reg(acc_pkg::REG_TAP_0, "REG_TAP_0", 32'hffff_f800);
    check_reg(acc_pkg::REG_TAP_3, "REG_TAP_3", 32'h0000_07ff);
    check_reg(acc_pkg::REG_TAP_7, "REG_TAP_7", 32'hffff_f9c3);
    apb_write(acc_pkg::REG_NTAPS, 32'd0);
    check_reg(acc_pkg::REG_NTAPS, "REG_NTAPS", 32'd8);
    apb_write(acc_pkg::REG_NTAPS, 32'd9);
    check_reg(acc_pkg::REG_NTAPS, "REG_NTAPS", 32'd8);
    apb_write(acc_pkg::REG_NTAPS, 32'd5);
    check_reg(acc_pkg::REG_NTAPS, "REG_NTAPS", 32'd5);
    finish_test();

    // ntaps stays at 5 from the readback test
    start_test("impulse response");
    for (int k = 0; k < NTAPS; k++)
    begin
      tap_val[k] = (k + 1) * 301 - 1200;
      apb_write(10'(acc_pkg::REG_TAP_0) + 10'(k), 32'(tap_val[k]));
    end
    apb_write(acc_pkg::REG_CONFIG, 32'h4);
    for (int k = 0; k < NTAPS; k++)
    begin
      apb_write(acc_pkg::REG_ACC_IN, (k == 0) ? 32'd1 : 32'd0);
      wait_not_empty();
      apb_read(acc_pkg::REG_ACC_OUT, rdata);
      check_value("REG_ACC_OUT", rdata, (k < 5) ? 32'(tap_val[k]) : 32'd0);
    end
    finish_test();

    start_test("random filtering");
    for (int k = 0; k < NTAPS; k++)
    begin
      rnd = $random(seed);
      tap_val[k] = $signed(rnd[IW-1:0]);
      apb_write(10'(acc_pkg::REG_TAP_0) + 10'(k), rnd);
    end
    rnd = $random(seed);
    apb_write(acc_pkg::REG_NTAPS, (rnd & 32'h7) + 32'd1);
    for (int i = 0; i < 40; i++)
    begin
      rnd = $random(seed);
      apb_write(acc_pkg::REG_ACC_IN, rnd);
      if (rnd[31] || i % 8 == 7)
        drain_fifo();
    end
    drain_fifo();
    check_reg(acc_pkg::REG_STATUS, "REG_STATUS", 32'h1);
    check_reg(acc_pkg::REG_ACC_OUT, "REG_ACC_OUT", 32'h0);
    finish_test();

    start_test("full fifo");
    apb_write(acc_pkg::REG_CONFIG, 32'h6);
    apb_write(acc_pkg::REG_CONFIG, 32'h4);
    for (int i = 0; i < FIFO_DEPTH + 3; i++)
      apb_write(acc_pkg::REG_ACC_IN, $random(seed));
    check_reg(acc_pkg::REG_STATUS, "REG_STATUS", 32'h6);
    for (int i = 0; i < FIFO_DEPTH; i++)
      apb_read(acc_pkg::REG_ACC_OUT, rdata);
    check_reg(acc_pkg::REG_STATUS, "REG_STATUS", 32'h5);
    apb_write(acc_pkg::REG_CONFIG, 32'h6);
    check_reg(acc_pkg::REG_STATUS, "REG_STATUS", 32'h1);
    apb_write(acc_pkg::REG_CONFIG, 32'h4);
    finish_test();

    start_test("clear and disable");
    // every tap active so stale samples would show up in the result
    apb_write(acc_pkg::REG_NTAPS, 32'(NTAPS));
    for (int i = 0; i < 3; i++)
      apb_write(acc_pkg::REG_ACC_IN, $random(seed));
    drain_fifo();
    apb_write(acc_pkg::REG_CONFIG, 32'h5);
    apb_write(acc_pkg::REG_CONFIG, 32'h4);
    // older samples are gone, so only tap 0 remains
    apb_write(acc_pkg::REG_ACC_IN, 32'd1);
    wait_not_empty();
    apb_read(acc_pkg::REG_ACC_OUT, rdata);
    check_value("REG_ACC_OUT", rdata, 32'(tap_val[0]));
    apb_write(acc_pkg::REG_CONFIG, 32'h0);
    for (int i = 0; i < 3; i++)
      apb_write(acc_pkg::REG_ACC_IN, $random(seed));
    check_reg(acc_pkg::REG_STATUS, "REG_STATUS", 32'h1);
    apb_write(acc_pkg::REG_CONFIG, 32'h4);
    check_reg(acc_pkg::REG_ACC_OUT, "REG_ACC_OUT", 32'h0);
    finish_test();

    $display("tests passed %0d, failing %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_errors() == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
hdl/acc_pkg.sv
hdl/acc_ifs.sv
hdl/apb_regs.sv
hdl/fir_filter.sv
hdl/result_fifo.sv
hdl/apb_acc_top.sv
dv/acc_checker.sv
dv/tb_apb_acc.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then decide on the log contents
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_apb_acc -f filelist.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or run error, see build.log and sim.log"; exit 1; }
! grep -q "TEST FAILED" sim.log && grep -q "TEST OK" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
